//--- Bender.yml
package:
  name: uart

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/uart_line_pkg.sv
      - common/uart_host_pkg.sv
      - uart/uart_rx.sv
      - uart/uart_tx.sv
      - hw/uart_ctrl.sv
      - hw/uart_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/uart_asserts.sv
      - bench/uart_tb.sv

//--- bench/uart_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module uart_asserts (
    input wire logic clk_uart,
    input wire logic rst_n,
    input wire logic req,
    input wire logic ack,
    input wire logic txd,
    input wire logic tx_busy,
    input wire logic rx_valid
);

    int fail_cnt = 0;

    // ack can only come up on an edge where req is high
    ack_rise_chk: assert property (@(posedge clk_uart) disable iff (!rst_n)
        !ack && !req |=> !ack)
        else begin
            $error("ack rose while req was low");
            fail_cnt++;
        end

    ack_fall_chk: assert property (@(posedge clk_uart) disable iff (!rst_n)
        ack && req |=> ack)
        else begin
            $error("ack fell while req was still high");
            fail_cnt++;
        end

    txd_idle_chk: assert property (@(posedge clk_uart) disable iff (!rst_n)
        !tx_busy |-> txd)
        else begin
            $error("txd low while transmitter idle");
            fail_cnt++;
        end

    rx_pulse_chk: assert property (@(posedge clk_uart) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else begin
            $error("rx_valid held for more than one cycle");
            fail_cnt++;
        end

endmodule

bind uart_top uart_asserts u_asserts (
    .clk_uart (clk_uart),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .txd      (txd),
    .tx_busy  (tx_busy),   // internal to uart_top
    .rx_valid (rx_valid)
);

`default_nettype wire

//--- bench/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_defs.svh"

module uart_tb;

    localparam int BIT        = `UART_BIT_CYCLES;
    localparam int FRAMES     = 7;
    localparam int TIMEOUT_NS = FRAMES * 12 * BIT * 40 + 40000;

    logic                     clk_uart;
    logic                     rst_n;
    logic                     req;
    logic                     rxd;
    logic                     ack;
    logic                     txd;
    uart_host_pkg::host_req_t host_req;
    uart_host_pkg::host_rsp_t host_rsp;
    logic [31:0]              seed;
    int                       err_cnt;

    uart_top dut (.*);

    initial begin
        clk_uart = 1'b0;
        forever #20 clk_uart = ~clk_uart;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("errors: %0d value checks, %0d assertions", err_cnt, dut.u_asserts.fail_cnt);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic uart_host_pkg::uart_status_t make_status(
        input logic rv, input logic fe, input logic ov, input logic busy);
        return '{rx_valid: rv, frame_err: fe, overrun: ov, tx_busy: busy};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic next_byte(output logic [7:0] b);
        seed = lcg_next(seed);
        b    = seed[23:16];  // upper bits mix better
    endtask

    task automatic host_xfer(input uart_host_pkg::host_op_t op, input logic [7:0] wdata,
                             output uart_host_pkg::host_rsp_t rsp, output int lat);
        int fall;
        @(posedge clk_uart);
        #2;
        host_req = '{op: op, wdata: wdata};
        req      = 1'b1;
        lat      = 0;
        fall     = 0;
        do begin
            @(posedge clk_uart);
            #2;
            lat++;
        end while (!ack);
        rsp = host_rsp;
        req = 1'b0;
        do begin
            @(posedge clk_uart);
            #2;
            fall++;
        end while (ack);
        check_eq("ack fall cycles", 1, fall);
        if (op != uart_host_pkg::OP_SEND) begin
            check_eq("ack rise cycles", 2, lat);
        end
    endtask

    task automatic drive_bit(input logic v, input int cycles);
        rxd = v;
        repeat (cycles) @(posedge clk_uart);
        #2;
    endtask

    task automatic send_serial(input logic [7:0] b, input logic stop);
        @(posedge clk_uart);
        #2;
        drive_bit(1'b0, BIT);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            drive_bit(b[i], BIT);
        end
        drive_bit(stop, BIT);
        drive_bit(1'b1, BIT);  // idle gap where rx_valid lands
    endtask

    task automatic expect_txd_frame(input logic [7:0] exp);
        logic [7:0] got;
        @(negedge txd);
        repeat (BIT / 2) @(posedge clk_uart);
        #2;
        check_eq("txd start bit", 0, txd);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            repeat (BIT) @(posedge clk_uart);
            #2;
            got[i] = txd;
        end
        check_eq("txd data", exp, got);
        repeat (BIT) @(posedge clk_uart);
        #2;
        check_eq("txd stop bit", 1, txd);
    endtask

    initial begin
        logic [7:0]               b1;
        logic [7:0]               b2;
        uart_host_pkg::host_rsp_t rsp;
        int                       lat;
        int                       lat2;
        rst_n    = 1'b0;
        req      = 1'b0;
        host_req = '0;
        rxd      = 1'b1;
        seed     = 32'hf5f;
        err_cnt  = 0;
        repeat (3) @(posedge clk_uart);
        #2;
        rst_n = 1'b1;

        check_eq("txd", 1, txd);
        check_eq("ack", 0, ack);
        host_xfer(uart_host_pkg::OP_STATUS, 8'h00, rsp, lat);
        check_eq("host_rsp.status", make_status(1'b0, 1'b0, 1'b0, 1'b0), rsp.status);

        next_byte(b1);
        next_byte(b2);
        fork
            begin
                expect_txd_frame(b1);
                expect_txd_frame(b2);
            end
            begin
                host_xfer(uart_host_pkg::OP_SEND, b1, rsp, lat);
                check_eq("host_rsp.rdata", 0, rsp.rdata);
                host_xfer(uart_host_pkg::OP_SEND, b2, rsp, lat2);  // must stall
                assert (lat2 > 9 * BIT) else begin
                    $display("second SEND was acked after %0d cycles, before the first frame ended",
                             lat2);
                    err_cnt++;
                end
            end
        join

        next_byte(b1);
        send_serial(b1, 1'b1);
        host_xfer(uart_host_pkg::OP_READ, 8'h00, rsp, lat);
        check_eq("host_rsp.rdata", b1, rsp.rdata);
        check_eq("host_rsp.status", make_status(1'b1, 1'b0, 1'b0, 1'b0), rsp.status);
        host_xfer(uart_host_pkg::OP_READ, 8'h00, rsp, lat);
        check_eq("host_rsp.status", make_status(1'b0, 1'b0, 1'b0, 1'b0), rsp.status);

        next_byte(b1);
        send_serial(b1, 1'b0);  // low stop bit
        host_xfer(uart_host_pkg::OP_READ, 8'h00, rsp, lat);
        check_eq("host_rsp.rdata", b1, rsp.rdata);
        check_eq("host_rsp.status", make_status(1'b1, 1'b1, 1'b0, 1'b0), rsp.status);
        host_xfer(uart_host_pkg::OP_STATUS, 8'h00, rsp, lat);
        check_eq("host_rsp.status", make_status(1'b0, 1'b0, 1'b0, 1'b0), rsp.status);

        next_byte(b1);
        next_byte(b2);
        send_serial(b1, 1'b1);
        send_serial(b2, 1'b1);
        host_xfer(uart_host_pkg::OP_STATUS, 8'h00, rsp, lat);
        check_eq("host_rsp.status", make_status(1'b1, 1'b0, 1'b1, 1'b0), rsp.status);
        host_xfer(uart_host_pkg::OP_READ, 8'h00, rsp, lat);
        check_eq("host_rsp.rdata", b1, rsp.rdata);
        host_xfer(uart_host_pkg::OP_STATUS, 8'h00, rsp, lat);
        check_eq("host_rsp.status", make_status(1'b0, 1'b0, 1'b0, 1'b0), rsp.status);

        // quarter-bit glitch that the mid-bit check rejects
        @(posedge clk_uart);
        #2;
        drive_bit(1'b0, BIT / 4);
        drive_bit(1'b1, 10 * BIT);
        host_xfer(uart_host_pkg::OP_STATUS, 8'h00, rsp, lat);
        check_eq("host_rsp.status", make_status(1'b0, 1'b0, 1'b0, 1'b0), rsp.status);

        repeat (4) @(posedge clk_uart);
        $display("errors: %0d value checks, %0d assertions", err_cnt, dut.u_asserts.fail_cnt);
        if (err_cnt == 0 && dut.u_asserts.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// clk_uart cycles per serial bit
// 16 gives 1.5625 Mbaud from a 25 MHz clock
`define UART_BIT_CYCLES 16

// rx bit counter runs down from UART_BIT_CYCLES-1 to 0
// so these sit at 1/4, 1/2 and 3/4 of the bit
`define UART_SAMPLE_1 (`UART_BIT_CYCLES * 3 / 4 - 1)
`define UART_SAMPLE_2 (`UART_BIT_CYCLES / 2 - 1)
`define UART_SAMPLE_3 (`UART_BIT_CYCLES / 4 - 1)

// data bits per frame without parity
`define UART_DATA_BITS 8

`endif

//--- common/uart_host_pkg.sv
`default_nettype none

package uart_host_pkg;

`include "uart_defs.svh"

    typedef enum logic [1:0] {
        OP_SEND   = 2'd0,
        OP_READ   = 2'd1,  // read clears the rx flags
        OP_STATUS = 2'd2
    } host_op_t;

    typedef struct packed {
        host_op_t                   op;
        logic [`UART_DATA_BITS-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic rx_valid;
        logic frame_err;
        logic overrun;
        logic tx_busy;
    } uart_status_t;

    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] rdata;
        uart_status_t               status;
    } host_rsp_t;

endpackage

`default_nettype wire

//--- common/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

`include "uart_defs.svh"

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_WAIT,       // count out one bit while sampling
        RX_START_CHK,
        RX_SHIFT,
        RX_STOP_CHK
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       frame_err;  // stop bit sampled low
    } rx_frame_t;

endpackage

`default_nettype wire

//--- hw/uart_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uart_ctrl (
    input  wire logic                      clk_uart,
    input  wire logic                      rst_n,
    input  wire logic                      req,
    input  wire uart_host_pkg::host_req_t  host_req,
    output logic                           ack,
    output uart_host_pkg::host_rsp_t       host_rsp,
    input  wire uart_line_pkg::rx_frame_t  rx_frame,
    input  wire logic                      rx_valid,
    output logic [7:0]                     tx_data,
    output logic                           tx_start,
    input  wire logic                      tx_busy
);

    typedef enum logic [1:0] {IDLE, EXEC, WAIT_TX, ACK} ctrl_state_t;

    ctrl_state_t                 state;
    uart_host_pkg::host_req_t    req_q;
    uart_host_pkg::uart_status_t status;
    logic [7:0]                  hold;
    logic                        rx_full;
    logic                        ferr;
    logic                        ovr;
    logic                        rsp_go;
    logic                        send_go;
    logic                        rd_clr;
    logic                        rx_take;

    assign status = '{rx_valid: rx_full, frame_err: ferr, overrun: ovr, tx_busy: tx_busy};
    assign tx_data = req_q.wdata;

    // SEND holds here until the transmitter is free
    assign rsp_go  = (state == EXEC || state == WAIT_TX) &&
                     (req_q.op != uart_host_pkg::OP_SEND || !tx_busy);
    assign send_go = rsp_go && (req_q.op == uart_host_pkg::OP_SEND);
    assign rd_clr  = rsp_go && (req_q.op == uart_host_pkg::OP_READ);
    assign rx_take = rx_valid && (!rx_full || rd_clr);  // a read frees the slot this cycle

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            ack      <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                IDLE:    if (req) state <= EXEC;
                EXEC, WAIT_TX: begin
                    if (rsp_go) begin
                        state    <= ACK;
                        ack      <= 1'b1;
                        tx_start <= send_go;
                    end else begin
                        state <= WAIT_TX;
                    end
                end
                ACK: begin
                    if (!req) begin
                        state <= IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            rx_full <= 1'b0;
            ferr    <= 1'b0;
            ovr     <= 1'b0;
        end else begin
            if (rd_clr) begin
                rx_full <= 1'b0;
                ferr    <= 1'b0;
                ovr     <= 1'b0;
            end
            if (rx_take) begin
                rx_full <= 1'b1;
                ferr    <= rx_frame.frame_err;
            end else if (rx_valid) begin
                ovr <= 1'b1;  // new byte dropped
            end
        end
    end

    always_ff @(posedge clk_uart) begin
        if (state == IDLE && req) begin
            req_q <= host_req;
        end
        if (rx_take) begin
            hold <= rx_frame.data;
        end
        if (rsp_go) begin
            host_rsp.rdata  <= (req_q.op == uart_host_pkg::OP_SEND) ? 8'h00 : hold;
            host_rsp.status <= status;
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top (
    input  wire logic                     clk_uart,
    input  wire logic                     rst_n,
    input  wire logic                     req,
    input  wire uart_host_pkg::host_req_t host_req,
    output logic                          ack,
    output uart_host_pkg::host_rsp_t      host_rsp,
    input  wire logic                     rxd,
    output logic                          txd
);

    uart_line_pkg::rx_frame_t rx_frame;
    logic                     rx_valid;
    logic [7:0]               tx_data;
    logic                     tx_start;
    logic                     tx_busy;

    uart_ctrl u_ctrl (
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .host_rsp (host_rsp),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy)
    );

    uart_rx u_rx (
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .rxd      (rxd),       // async pin synchronized inside uart_rx
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

    uart_tx u_tx (
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/uart_line_pkg.sv
common/uart_host_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hw/uart_ctrl.sv
hw/uart_top.sv
bench/uart_asserts.sv
bench/uart_tb.sv

//--- uart/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_defs.svh"

module uart_rx (
    input  wire logic                clk_uart,
    input  wire logic                rst_n,
    input  wire logic                rxd,
    output uart_line_pkg::rx_frame_t rx_frame,
    output logic                     rx_valid
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam int IDX_W = $clog2(`UART_DATA_BITS);

    uart_line_pkg::rx_state_t   state;
    uart_line_pkg::rx_state_t   next_state;
    logic                       rxd_meta;
    logic                       rxd_sync;
    logic [CNT_W-1:0]           cnt;
    logic [IDX_W-1:0]           bit_idx;
    logic [2:0]                 samples;
    logic [`UART_DATA_BITS-1:0] shreg;
    logic                       vote;
    logic                       bit_end;
    logic                       sample_hit;

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;  // line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // 2 of 3
    assign vote = (samples[0] & samples[1]) |
                  (samples[1] & samples[2]) |
                  (samples[0] & samples[2]);

    assign bit_end    = (cnt == '0);
    assign sample_hit = (state != uart_line_pkg::RX_IDLE) &&
                        ((cnt == CNT_W'(`UART_SAMPLE_1)) ||
                         (cnt == CNT_W'(`UART_SAMPLE_2)) ||
                         (cnt == CNT_W'(`UART_SAMPLE_3)));

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state      <= uart_line_pkg::RX_IDLE;
            next_state <= uart_line_pkg::RX_IDLE;
            cnt        <= CNT_W'(`UART_BIT_CYCLES - 1);
            bit_idx    <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;

            // free-running per bit once a start edge is seen
            if (state == uart_line_pkg::RX_IDLE && rxd_sync) begin
                cnt <= CNT_W'(`UART_BIT_CYCLES - 1);
            end else if (bit_end) begin
                cnt <= CNT_W'(`UART_BIT_CYCLES - 1);
            end else begin
                cnt <= cnt - 1'b1;
            end

            case (state)
                uart_line_pkg::RX_IDLE: begin
                    if (!rxd_sync) begin
                        state      <= uart_line_pkg::RX_WAIT;
                        next_state <= uart_line_pkg::RX_START_CHK;
                    end
                end
                uart_line_pkg::RX_WAIT: begin
                    if (bit_end) begin
                        state <= next_state;
                    end
                end
                uart_line_pkg::RX_START_CHK: begin
                    if (vote) begin
                        state <= uart_line_pkg::RX_IDLE;  // glitch rather than a start bit
                    end else begin
                        state      <= uart_line_pkg::RX_WAIT;
                        next_state <= uart_line_pkg::RX_SHIFT;
                        bit_idx    <= '0;
                    end
                end
                uart_line_pkg::RX_SHIFT: begin
                    state   <= uart_line_pkg::RX_WAIT;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) begin
                        next_state <= uart_line_pkg::RX_STOP_CHK;
                    end
                end
                uart_line_pkg::RX_STOP_CHK: begin
                    rx_valid <= 1'b1;  // delivered even on a bad stop bit
                    state    <= uart_line_pkg::RX_IDLE;
                end
                default: state <= uart_line_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_uart) begin
        if (sample_hit) begin
            samples <= {samples[1:0], rxd_sync};
        end
        if (state == uart_line_pkg::RX_SHIFT) begin
            shreg <= {vote, shreg[`UART_DATA_BITS-1:1]};  // lsb first
        end
        if (state == uart_line_pkg::RX_STOP_CHK) begin
            rx_frame.data      <= shreg;
            rx_frame.frame_err <= ~vote;
        end
    end

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_defs.svh"

module uart_tx (
    input  wire logic                       clk_uart,
    input  wire logic                       rst_n,
    input  wire logic [`UART_DATA_BITS-1:0] tx_data,
    input  wire logic                       tx_start,
    output logic                            tx_busy,
    output logic                            txd
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam int IDX_W = $clog2(`UART_DATA_BITS);

    uart_line_pkg::tx_state_t   state;
    logic [CNT_W-1:0]           cnt;
    logic [IDX_W-1:0]           bit_idx;
    logic [`UART_DATA_BITS-1:0] shreg;
    logic                       bit_end;

    assign bit_end = (cnt == '0);
    assign tx_busy = (state != uart_line_pkg::TX_IDLE);

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_line_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            if (state != uart_line_pkg::TX_IDLE) begin
                cnt <= bit_end ? CNT_W'(`UART_BIT_CYCLES - 1) : cnt - 1'b1;
            end

            case (state)
                uart_line_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        state <= uart_line_pkg::TX_START;
                        cnt   <= CNT_W'(`UART_BIT_CYCLES - 1);
                        txd   <= 1'b0;  // start bit
                    end
                end
                uart_line_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= uart_line_pkg::TX_DATA;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                    end
                end
                uart_line_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) begin
                            state <= uart_line_pkg::TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shreg[0];
                        end
                    end
                end
                uart_line_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= uart_line_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_line_pkg::TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_uart) begin
        if (state == uart_line_pkg::TX_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (bit_end && (state == uart_line_pkg::TX_START ||
                                 state == uart_line_pkg::TX_DATA)) begin
            shreg <= shreg >> 1;  // next bit into [0]
        end
    end

endmodule

`default_nettype wire
